//--- cache_top.f
hdl/cache_pkg.sv
hdl/cache_array.sv
hdl/plru_manager.sv
hdl/cache_datapath_core.sv
hdl/cache_control.sv
hdl/cache_top.sv
testbench/cache_properties.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

//--- Makefile
TOP = cache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f cache_top.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f cache_top.f

clean:
	rm -rf obj_dir

//--- testbench/cache_tb.sv
`default_nettype none

// Sparse line memory answering after a random delay
module mem_slave (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         mem_cyc,
    input  logic                         mem_stb,
    input  logic                         mem_we,
    input  logic [cache_pkg::ADDR_W-1:0] mem_adr,
    input  logic [cache_pkg::LINE_W-1:0] mem_dat_w,
    output logic [cache_pkg::LINE_W-1:0] mem_dat_r,
    output logic                         mem_ack
);

    import cache_pkg::*;

    logic [LINE_W-1:0] lines [logic [ADDR_W-1:0]];

    function automatic logic [LINE_W-1:0] line_pattern(input logic [ADDR_W-1:0] a);
        logic [LINE_W-1:0] l;
        for (int k = 0; k < LINE_W / 32; k++) begin
            l[k*32 +: 32] = a ^ (32'h9e37_79b9 * 32'(k + 1));
        end
        return l;
    endfunction

    initial begin
        int unsigned delay;
        logic        busy;
        mem_ack   = 1'b0;
        mem_dat_r = '0;
        busy      = 1'b0;
        delay     = 0;
        forever begin
            @(negedge clk);
            if (rst || mem_ack) begin
                mem_ack = 1'b0;
                busy    = 1'b0;
            end else if (mem_cyc && mem_stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom_range(5, 0);
                end
                if (delay != 0) begin
                    delay--;
                end else begin
                    if (mem_we) begin
                        lines[mem_adr] = mem_dat_w;
                    end else if (lines.exists(mem_adr)) begin
                        mem_dat_r = lines[mem_adr];
                    end else begin
                        mem_dat_r = line_pattern(mem_adr);
                    end
                    mem_ack = 1'b1;
                end
            end
        end
    end

endmodule

module cache_tb;

    import cache_pkg::*;

    localparam int tag_w      = ADDR_W - S_OFFSET_DEF - S_INDEX_DEF;
    localparam int num_random = 400;
    localparam int ack_limit  = 200;
    localparam int rst_limit  = 10;

    logic              clk;
    logic              rst;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [LINE_W-1:0] dat_w;
    logic [LINE_W-1:0] dat_r;
    logic              ack;
    logic              mem_cyc;
    logic              mem_stb;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_adr;
    logic [LINE_W-1:0] mem_dat_w;
    logic [LINE_W-1:0] mem_dat_r;
    logic              mem_ack;
    int                error_count;
    int                check_count;
    int                base_errors;
    int                requests;
    event              timeout_seen;
    string             timeout_what;

    cache_top i_cache_top (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .mem_cyc(mem_cyc), .mem_stb(mem_stb),
        .mem_we(mem_we), .mem_adr(mem_adr), .mem_dat_w(mem_dat_w),
        .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
    );

    cache_checker i_cache_checker (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .mem_cyc(mem_cyc), .mem_stb(mem_stb),
        .mem_we(mem_we), .mem_adr(mem_adr), .mem_dat_w(mem_dat_w), .mem_ack(mem_ack),
        .error_count(error_count), .check_count(check_count)
    );

    mem_slave i_mem_slave (
        .clk(clk), .rst(rst), .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we),
        .mem_adr(mem_adr), .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
    );

    always #10 clk = ~clk;

    initial begin
        @(timeout_seen);
        $display("Timeout waiting for %s", timeout_what);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic abort_on_timeout(input string what);
        timeout_what = what;
        -> timeout_seen;
    endtask

    // Six tags on two indices overflow the four ways
    function automatic logic [ADDR_W-1:0] make_addr(input int t, input int i);
        logic [tag_w-1:0]        tag;
        logic [S_INDEX_DEF-1:0]  index;
        logic [S_OFFSET_DEF-1:0] offset;
        tag    = tag_w'(32'h005a_0000 + 32'(t) * 32'h0000_1234);
        index  = (i == 0) ? S_INDEX_DEF'(2) : S_INDEX_DEF'(5);
        offset = S_OFFSET_DEF'($urandom);
        return {tag, index, offset};
    endfunction

    function automatic logic [LINE_W-1:0] rand_line();
        logic [LINE_W-1:0] l;
        for (int k = 0; k < LINE_W / 32; k++) begin
            l[k*32 +: 32] = $urandom;
        end
        return l;
    endfunction

    // Entered and left on a falling edge with the strobe low for one cycle after
    task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] a,
                              input logic [LINE_W-1:0] d);
        int n;
        n     = 0;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = d;
        @(negedge clk);
        while (!ack) begin
            n++;
            if (n > ack_limit) begin
                abort_on_timeout("ack");
            end
            @(negedge clk);
        end
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge clk);
        requests++;
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d requests, %0d errors", name, requests, error_count - base_errors);
        requests    = 0;
        base_errors = error_count;
    endtask

    initial begin
        int                n;
        logic              wr;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] last_a;
        void'($urandom(74499));
        clk         = 1'b0;
        rst         = 1'b1;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        requests    = 0;
        base_errors = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        n   = 0;
        while (ack || mem_cyc || mem_stb) begin
            n++;
            if (n > rst_limit) begin
                abort_on_timeout("an idle bus after reset");
            end
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        report_test("reset");

        // Cold miss, write hit, read back, then a write miss and its read
        a = make_addr(0, 0);
        bus_access(1'b0, a, '0);
        bus_access(1'b1, a, rand_line());
        bus_access(1'b0, a, '0);
        a = make_addr(3, 1);
        bus_access(1'b1, a, rand_line());
        bus_access(1'b0, a, '0);
        report_test("directed");

        last_a = a;
        for (int i = 0; i < num_random; i++) begin
            wr = ($urandom_range(1, 0) == 1);
            if ($urandom_range(3, 0) == 0) begin
                a = last_a;
            end else begin
                a = make_addr($urandom_range(5, 0), $urandom_range(1, 0));
            end
            bus_access(wr, a, wr ? rand_line() : '0);
            last_a = a;
        end
        report_test("random");

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cache_checker.sv
`default_nettype none

module cache_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [cache_pkg::ADDR_W-1:0] adr,
    input  logic [cache_pkg::LINE_W-1:0] dat_w,
    input  logic [cache_pkg::LINE_W-1:0] dat_r,
    input  logic                         ack,
    input  logic                         mem_cyc,
    input  logic                         mem_stb,
    input  logic                         mem_we,
    input  logic [cache_pkg::ADDR_W-1:0] mem_adr,
    input  logic [cache_pkg::LINE_W-1:0] mem_dat_w,
    input  logic                         mem_ack,
    output int                           error_count,
    output int                           check_count
);

    import cache_pkg::*;

    // Latest line written by the processor, keyed by line address
    logic [LINE_W-1:0] model [logic [ADDR_W-1:0]];

    logic              started;
    logic              in_req;
    logic              down_seen;
    logic              have_prev;
    logic              req_we;
    logic [ADDR_W-1:0] req_line;
    logic [ADDR_W-1:0] prev_line;
    logic [LINE_W-1:0] req_data;
    logic [LINE_W-1:0] expected;
    int                cycles;

    function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:S_OFFSET_DEF], {S_OFFSET_DEF{1'b0}}};
    endfunction

    // Contents of a line that memory has never been written with
    function automatic logic [LINE_W-1:0] line_pattern(input logic [ADDR_W-1:0] a);
        logic [LINE_W-1:0] l;
        for (int k = 0; k < LINE_W / 32; k++) begin
            l[k*32 +: 32] = a ^ (32'h9e37_79b9 * 32'(k + 1));
        end
        return l;
    endfunction

    task automatic check_line(input string name, input logic [LINE_W-1:0] exp,
                              input logic [LINE_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error: %s at time %0t", msg, $time);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            error_count = 0;
            check_count = 0;
            started     = 1'b0;
            in_req      = 1'b0;
            have_prev   = 1'b0;
        end else begin
            if (!started && (ack || mem_cyc || mem_stb)) begin
                report_error("bus activity before the first request");
            end
            if (cyc && stb && !in_req) begin
                started   = 1'b1;
                in_req    = 1'b1;
                down_seen = 1'b0;
                cycles    = 0;
                req_we    = we;
                req_line  = line_of(adr);
                req_data  = dat_w;
            end
            if (in_req) begin
                cycles++;
            end
            if (mem_cyc && mem_stb) begin
                down_seen = 1'b1;
            end
            if (mem_stb && mem_ack) begin
                check_addr("mem_adr", line_of(mem_adr), mem_adr);
                if (!mem_we) begin
                    check_addr("mem_adr", req_line, mem_adr);
                end else if (model.exists(mem_adr)) begin
                    check_line("mem_dat_w", model[mem_adr], mem_dat_w);
                end else begin
                    report_error("write-back of a line that was never written");
                end
            end
            if (ack && !in_req) begin
                report_error("ack with no pending request");
            end else if (ack) begin
                if (req_we) begin
                    model[req_line] = req_data;
                end else begin
                    expected = model.exists(req_line) ? model[req_line] : line_pattern(req_line);
                    check_line("dat_r", expected, dat_r);
                    if (have_prev && prev_line == req_line) begin
                        if (down_seen) begin
                            report_error("read of the previous line started a memory cycle");
                        end
                        if (cycles != 2) begin
                            report_error("read of the previous line missed the second cycle");
                        end
                    end
                end
                prev_line = req_line;
                have_prev = 1'b1;
                in_req    = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/cache_properties.sv
`default_nettype none

module cache_properties (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic mem_stb,
    input logic mem_we,
    input logic mem_ack,
    input logic downstream_address_sel
);

    // Processor ack only inside an active strobe
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (rst) ack |-> (cyc && stb)
    ) else $error("ack raised without cyc and stb");

    // Memory request and its address source held until acknowledged
    a_mem_hold: assert property (
        @(posedge clk) disable iff (rst)
        (mem_stb && !mem_ack) |=>
            (mem_stb && $stable(mem_we) && $stable(downstream_address_sel))
    ) else $error("memory request changed before mem_ack");

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    ) else $error("ack held for two cycles");

endmodule

bind cache_control cache_properties i_cache_properties (
    .clk                   (clk),
    .rst                   (rst),
    .cyc                   (cyc),
    .stb                   (stb),
    .ack                   (ack),
    .mem_stb               (mem_stb),
    .mem_we                (mem_we),
    .mem_ack               (mem_ack),
    .downstream_address_sel(downstream_address_sel)
);

`default_nettype wire

//--- hdl/cache_top.sv
`default_nettype none

module cache_top #(
    parameter int s_offset = cache_pkg::S_OFFSET_DEF,
    parameter int s_index  = cache_pkg::S_INDEX_DEF,
    parameter int s_way    = cache_pkg::S_WAY_DEF
) (
    input  logic                         clk,
    input  logic                         rst,

    // Processor side, Wishbone slave
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [cache_pkg::ADDR_W-1:0] adr,
    input  logic [cache_pkg::LINE_W-1:0] dat_w,
    output logic [cache_pkg::LINE_W-1:0] dat_r,
    output logic                         ack,

    // Memory side, Wishbone master
    output logic                         mem_cyc,
    output logic                         mem_stb,
    output logic                         mem_we,
    output logic [cache_pkg::ADDR_W-1:0] mem_adr,
    output logic [cache_pkg::LINE_W-1:0] mem_dat_w,
    input  logic [cache_pkg::LINE_W-1:0] mem_dat_r,
    input  logic                         mem_ack
);

    logic hit;
    logic valid;
    logic dirty;
    logic cache_read;
    logic cache_load_en;
    logic new_dirty;
    logic ld_wb;
    logic ld_lru;
    logic downstream_address_sel;

    cache_control #(
        .s_offset(s_offset),
        .s_index (s_index),
        .s_way   (s_way)
    ) i_cache_control (
        .clk                   (clk),
        .rst                   (rst),
        .cyc                   (cyc),
        .stb                   (stb),
        .we                    (we),
        .ack                   (ack),
        .mem_cyc               (mem_cyc),
        .mem_stb               (mem_stb),
        .mem_we                (mem_we),
        .mem_ack               (mem_ack),
        .hit                   (hit),
        .valid                 (valid),
        .dirty                 (dirty),
        .cache_read            (cache_read),
        .cache_load_en         (cache_load_en),
        .new_dirty             (new_dirty),
        .ld_wb                 (ld_wb),
        .ld_lru                (ld_lru),
        .downstream_address_sel(downstream_address_sel)
    );

    cache_datapath_core #(
        .s_offset(s_offset),
        .s_index (s_index),
        .s_way   (s_way)
    ) i_cache_datapath_core (
        .clk                   (clk),
        .rst                   (rst),
        .cache_read            (cache_read),
        .cache_load_en         (cache_load_en),
        .downstream_address_sel(downstream_address_sel),
        .ld_wb                 (ld_wb),
        .ld_lru                (ld_lru),
        .new_dirty             (new_dirty),
        .hit                   (hit),
        .valid                 (valid),
        .dirty                 (dirty),
        .upstream_address      (adr),
        .upstream_wdata        (dat_w),
        .upstream_rdata        (dat_r),
        .downstream_rdata      (mem_dat_r),
        .downstream_wdata      (mem_dat_w),
        .downstream_address    (mem_adr)
    );

endmodule

`default_nettype wire

//--- hdl/cache_control.sv
`default_nettype none

module cache_control #(
    parameter int s_offset = cache_pkg::S_OFFSET_DEF,
    parameter int s_index  = cache_pkg::S_INDEX_DEF,
    parameter int s_way    = cache_pkg::S_WAY_DEF
) (
    input  logic clk,
    input  logic rst,

    // Processor side handshake
    input  logic cyc,
    input  logic stb,
    input  logic we,
    output logic ack,

    // Memory side handshake
    output logic mem_cyc,
    output logic mem_stb,
    output logic mem_we,
    input  logic mem_ack,

    // Datapath status and strobes
    input  logic hit,
    input  logic valid,
    input  logic dirty,
    output logic cache_read,
    output logic cache_load_en,
    output logic new_dirty,
    output logic ld_wb,
    output logic ld_lru,
    output logic downstream_address_sel
);

    import cache_pkg::*;

    localparam int s_tag = ADDR_W - s_offset - s_index;

    if (s_tag < 1 || s_way < 1) begin : g_geometry_check
        $error("Cache geometry leaves no tag bits or no ways");
    end

    ctrl_state_t state;
    ctrl_state_t state_next;

    // Idle cycle on the memory bus between write-back and fill
    logic wb_gap;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            wb_gap <= 1'b0;
        end else begin
            state  <= state_next;
            wb_gap <= (state == WRITEBACK) && mem_ack;
        end
    end

    always_comb begin
        state_next             = state;
        ack                    = 1'b0;
        mem_cyc                = 1'b0;
        mem_stb                = 1'b0;
        mem_we                 = 1'b0;
        cache_read             = 1'b0;
        cache_load_en          = 1'b0;
        new_dirty              = 1'b0;
        ld_wb                  = 1'b0;
        ld_lru                 = 1'b0;
        downstream_address_sel = 1'b0;

        case (state)
            IDLE: begin
                if (cyc && stb) begin
                    cache_read = 1'b1;
                    state_next = CHECK;
                end
            end
            CHECK: begin
                if (hit) begin
                    ack    = 1'b1;
                    ld_lru = 1'b1;
                    // Write hit marks the line dirty
                    if (we) begin
                        cache_load_en = 1'b1;
                        new_dirty     = 1'b1;
                    end
                    state_next = IDLE;
                end else if (valid && dirty) begin
                    ld_wb      = 1'b1;
                    state_next = WRITEBACK;
                end else begin
                    state_next = FILL;
                end
            end
            WRITEBACK: begin
                mem_cyc                = 1'b1;
                mem_stb                = 1'b1;
                mem_we                 = 1'b1;
                downstream_address_sel = 1'b1;
                if (mem_ack) begin
                    state_next = FILL;
                end
            end
            FILL: begin
                if (!wb_gap) begin
                    mem_cyc = 1'b1;
                    mem_stb = 1'b1;
                    // Line arrives clean with tag and valid set
                    if (mem_ack) begin
                        cache_load_en = 1'b1;
                        state_next    = RECHECK;
                    end
                end
            end
            RECHECK: begin
                cache_read = 1'b1;
                state_next = CHECK;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/cache_datapath_core.sv
`default_nettype none

module cache_datapath_core #(
    parameter  int s_offset = cache_pkg::S_OFFSET_DEF,
    parameter  int s_index  = cache_pkg::S_INDEX_DEF,
    parameter  int s_way    = cache_pkg::S_WAY_DEF,
    localparam int s_tag    = cache_pkg::ADDR_W - s_offset - s_index,
    localparam int num_ways = 2**s_way
) (
    input  logic                         clk,
    input  logic                         rst,

    // From the controller
    input  logic                         cache_read,
    input  logic                         cache_load_en,
    input  logic                         downstream_address_sel,
    input  logic                         ld_wb,
    input  logic                         ld_lru,
    input  logic                         new_dirty,
    output logic                         hit,
    output logic                         valid,
    output logic                         dirty,

    // Processor side
    input  logic [cache_pkg::ADDR_W-1:0] upstream_address,
    input  logic [cache_pkg::LINE_W-1:0] upstream_wdata,
    output logic [cache_pkg::LINE_W-1:0] upstream_rdata,

    // Memory side
    input  logic [cache_pkg::LINE_W-1:0] downstream_rdata,
    output logic [cache_pkg::LINE_W-1:0] downstream_wdata,
    output logic [cache_pkg::ADDR_W-1:0] downstream_address
);

    import cache_pkg::*;

    logic [s_tag-1:0]    tag;
    logic [s_index-1:0]  index;

    logic [num_ways-1:0] way;
    logic [num_ways-1:0] hits;
    logic [num_ways-1:0] valids;
    logic [num_ways-1:0] dirtys;
    logic [num_ways-2:0] lru;
    logic [num_ways-2:0] new_lru;

    logic [s_tag-1:0]    tags  [num_ways];
    logic [LINE_W-1:0]   datas [num_ways];

    logic [s_tag-1:0]    victim_tag;
    logic [LINE_W-1:0]   way_data;
    logic [LINE_W-1:0]   line_in;
    logic [LINE_W-1:0]   wb_line;

    assign tag   = upstream_address[ADDR_W-1:s_offset+s_index];
    assign index = upstream_address[s_offset+s_index-1:s_offset];

    plru_manager #(
        .s_way(s_way)
    ) i_plru (
        .lru    (lru),
        .hits   (hits),
        .way    (way),
        .new_lru(new_lru)
    );

    cache_array #(
        .s_index  (s_index),
        .payload_t(logic [num_ways-2:0])
    ) i_lru_array (
        .clk    (clk),
        .rst    (rst),
        .index  (index),
        .read   (cache_read),
        .load   (ld_lru),
        .datain (new_lru),
        .dataout(lru)
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        logic way_load;

        assign way_load = cache_load_en & way[w];

        cache_array #(
            .s_index  (s_index),
            .payload_t(logic)
        ) i_valid_array (
            .clk    (clk),
            .rst    (rst),
            .index  (index),
            .read   (cache_read),
            .load   (way_load),
            .datain (1'b1),
            .dataout(valids[w])
        );

        cache_array #(
            .s_index  (s_index),
            .payload_t(logic)
        ) i_dirty_array (
            .clk    (clk),
            .rst    (rst),
            .index  (index),
            .read   (cache_read),
            .load   (way_load),
            .datain (new_dirty),
            .dataout(dirtys[w])
        );

        cache_array #(
            .s_index  (s_index),
            .payload_t(logic [s_tag-1:0])
        ) i_tag_array (
            .clk    (clk),
            .rst    (rst),
            .index  (index),
            .read   (cache_read),
            .load   (way_load),
            .datain (tag),
            .dataout(tags[w])
        );

        cache_array #(
            .s_index  (s_index),
            .payload_t(logic [LINE_W-1:0])
        ) i_data_array (
            .clk    (clk),
            .rst    (rst),
            .index  (index),
            .read   (cache_read),
            .load   (way_load),
            .datain (line_in),
            .dataout(datas[w])
        );

        assign hits[w] = valids[w] && (tags[w] == tag);
    end

    assign hit = |hits;

    // Way select, the hit way or else the victim
    always_comb begin
        valid      = 1'b0;
        dirty      = 1'b0;
        victim_tag = '0;
        way_data   = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way[w]) begin
                valid      = valids[w];
                dirty      = dirtys[w];
                victim_tag = tags[w];
                way_data   = datas[w];
            end
        end
    end

    // Write hits store processor data, fills store memory data
    assign line_in = hit ? upstream_wdata : downstream_rdata;

    assign upstream_rdata = way_data;

    // Victim line held for the write-back burst
    always_ff @(posedge clk) begin
        if (ld_wb) begin
            wb_line <= way_data;
        end
    end

    assign downstream_wdata = wb_line;

    assign downstream_address = downstream_address_sel ?
        {victim_tag, index, {s_offset{1'b0}}} :
        {upstream_address[ADDR_W-1:s_offset], {s_offset{1'b0}}};

endmodule

`default_nettype wire

//--- hdl/plru_manager.sv
`default_nettype none

module plru_manager #(
    parameter  int s_way    = cache_pkg::S_WAY_DEF,
    localparam int num_ways = 2**s_way
) (
    input  logic [num_ways-2:0] lru,
    input  logic [num_ways-1:0] hits,
    output logic [num_ways-1:0] way,
    output logic [num_ways-2:0] new_lru
);

    // Tree nodes in heap order, node n has children 2n+1 and 2n+2
    // A node bit of 1 means the older half is on the right
    logic [s_way-1:0] sel_idx;

    always_comb begin
        int unsigned node;
        node    = 0;
        sel_idx = '0;
        if (|hits) begin
            for (int i = 0; i < num_ways; i++) begin
                if (hits[i]) begin
                    sel_idx = s_way'(i);
                end
            end
        end else begin
            // Walk toward the least recently used leaf
            for (int l = 0; l < s_way; l++) begin
                sel_idx[s_way-1-l] = lru[node];
                node = 2 * node + 1 + lru[node];
            end
        end
        way          = '0;
        way[sel_idx] = 1'b1;
    end

    always_comb begin
        int unsigned node;
        logic        b;
        node    = 0;
        new_lru = lru;
        // Point every node on the path away from the chosen way
        for (int l = 0; l < s_way; l++) begin
            b             = sel_idx[s_way-1-l];
            new_lru[node] = ~b;
            node          = 2 * node + 1 + b;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cache_array.sv
`default_nettype none

module cache_array #(
    parameter int  s_index   = cache_pkg::S_INDEX_DEF,
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [s_index-1:0] index,
    input  logic               read,
    input  logic               load,
    input  payload_t           datain,
    output payload_t           dataout
);

    localparam int num_sets = 2**s_index;

    payload_t store [num_sets];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                store[s] <= '0;
            end
            dataout <= '0;
        end else begin
            // A load also shows the new payload on the output
            if (load) begin
                store[index] <= datain;
                dataout      <= datain;
            end else if (read) begin
                dataout <= store[index];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Address geometry
    localparam int ADDR_W       = 32;
    localparam int S_OFFSET_DEF = 5;
    localparam int S_INDEX_DEF  = 3;
    localparam int S_WAY_DEF    = 2;

    // One line is 2**offset bytes
    localparam int LINE_W = 8 * (2**S_OFFSET_DEF);

    // Controller sequence for a single request
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        CHECK     = 3'd1,
        WRITEBACK = 3'd2,
        FILL      = 3'd3,
        RECHECK   = 3'd4
    } ctrl_state_t;

endpackage

`default_nettype wire
